//--- vlog.f
logic/mm_pkg.sv
logic/mm_pe.sv
logic/mm_feeder.sv
logic/mm_drain.sv
logic/dma_engine.sv
logic/mm_top.sv
bench/tb_axi_mem.sv
bench/tb_mm_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the matrix-multiply bench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_mm_top -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_mm_top" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- bench/tb_mm_top.sv
// bench top for the matrix-multiply subsystem
// clock, reset, run sequence, reference sums, assertions and report
`timescale 1ns/1ps
`default_nettype none

module tb_mm_top;

    localparam int RUNS       = 8;
    localparam int RUN_CYCLES = 200;
    localparam int MAX_CYCLES = RUNS * RUN_CYCLES + 50;
    localparam int ELEMS      = mm_pkg::SA_N * mm_pkg::SA_N;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic        done;
    logic [31:0] a_addr, b_addr, c_addr;

    mm_pkg::ar_chan_t ar;
    mm_pkg::r_chan_t  r;
    mm_pkg::aw_chan_t aw;
    mm_pkg::w_chan_t  w;
    mm_pkg::b_chan_t  b;
    logic             ar_ready, r_ready, aw_ready, w_ready, b_ready;
    mm_pkg::dma_state_t state;

    // expected request addresses and C of the current run
    logic [31:0]  exp_a_addr, exp_b_addr, exp_c_addr;
    mm_pkg::acc_t exp_c [ELEMS];

    int value_errs = 0;
    int proto_errs = 0;
    int cycles     = 0;
    int ar_seen    = 0;
    int wbeat      = 0;
    int accept_cnt = 0;
    int done_cnt   = 0;

    always #2 clk = ~clk;

    mm_top i_dut (
        .clk, .rst_n, .mat_a_addr_i(a_addr), .mat_b_addr_i(b_addr), .mat_c_addr_i(c_addr),
        .start_i(start), .done_o(done), .ar_o(ar), .ar_ready_i(ar_ready), .r_i(r),
        .r_ready_o(r_ready), .aw_o(aw), .aw_ready_i(aw_ready), .w_o(w),
        .w_ready_i(w_ready), .b_i(b), .b_ready_o(b_ready)
    );

    tb_axi_mem i_mem (
        .clk, .rst_n, .ar_i(ar), .ar_ready_o(ar_ready), .r_o(r), .r_ready_i(r_ready),
        .aw_i(aw), .aw_ready_o(aw_ready), .w_i(w), .w_ready_o(w_ready),
        .b_o(b), .b_ready_i(b_ready)
    );

    assign state = i_dut.i_dma.state_q;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            value_errs++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // count a protocol violation and say what it was
    task automatic report_protocol_error(input string what);
        proto_errs++;
        $display("%s", what);
    endtask

    // signed row-by-column sums from the words in the memory model
    task automatic compute_expected();
        logic [31:0]       wa, wb;
        logic signed [7:0] ea, eb;
        int                sum;
        for (int i = 0; i < mm_pkg::SA_N; i++) begin
            for (int j = 0; j < mm_pkg::SA_N; j++) begin
                sum = 0;
                for (int k = 0; k < mm_pkg::SA_N; k++) begin
                    wa  = i_mem.mem[(exp_a_addr >> 2) + i];
                    wb  = i_mem.mem[(exp_b_addr >> 2) + k];
                    ea  = wa[8*k +: 8];
                    eb  = wb[8*j +: 8];
                    sum = sum + ea * eb;
                end
                exp_c[i*mm_pkg::SA_N+j] = sum;
            end
        end
    endtask

    // one run with its own region, plus a start pulse while busy
    task automatic run_matrix(input int run);
        exp_a_addr = run * 128;
        exp_b_addr = run * 128 + 16;
        exp_c_addr = run * 128 + 64;
        compute_expected();
        a_addr <= exp_a_addr;
        b_addr <= exp_b_addr;
        c_addr <= exp_c_addr;
        start  <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (state != mm_pkg::WAIT_MM) @(posedge clk);
        a_addr <= '1;
        b_addr <= '1;
        c_addr <= '1;
        start  <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!done) @(posedge clk);
    endtask

    // per-handshake value checks
    always @(posedge clk) begin
        if (rst_n) begin
            if (start && state == mm_pkg::IDLE) begin
                accept_cnt <= accept_cnt + 1;
                ar_seen    <= 0;
            end
            if (ar.valid && ar_ready) begin
                check_value("read id", (ar_seen == 0) ? mm_pkg::ID_A : mm_pkg::ID_B, ar.id);
                check_value("read addr", (ar_seen == 0) ? exp_a_addr : exp_b_addr, ar.addr);
                check_value("read len", mm_pkg::RD_LEN, ar.len);
                check_value("read size", mm_pkg::SIZE_4B, ar.size);
                check_value("read burst", mm_pkg::BURST_INCR, ar.burst);
                ar_seen <= ar_seen + 1;
            end
            if (aw.valid && aw_ready) begin
                check_value("write addr", exp_c_addr, aw.addr);
                check_value("write len", mm_pkg::WR_LEN, aw.len);
                check_value("write size", mm_pkg::SIZE_4B, aw.size);
                check_value("write burst", mm_pkg::BURST_INCR, aw.burst);
                wbeat <= 0;
            end
            if (w.valid && w_ready) begin
                if (wbeat < ELEMS) begin
                    check_value($sformatf("c element %0d", wbeat), exp_c[wbeat], w.data);
                end
                check_value($sformatf("last on beat %0d", wbeat), wbeat == ELEMS - 1, w.last);
                check_value("write strobes", 4'hf, w.strb);
                wbeat <= wbeat + 1;
            end
            if (b.valid && b_ready) begin
                check_value("read requests per run", 2, ar_seen);
                check_value("write beats per run", ELEMS, wbeat);
            end
            if (done) begin
                done_cnt <= done_cnt + 1;
            end
        end
    end

    // valid and payload hold under back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        (ar.valid && !ar_ready) |=> (ar.valid && $stable(ar)))
        else report_protocol_error("read request changed while stalled");
    assert property (@(posedge clk) disable iff (!rst_n)
        (r.valid && !r_ready) |=> (r.valid && $stable(r)))
        else report_protocol_error("read data changed while stalled");
    assert property (@(posedge clk) disable iff (!rst_n)
        (aw.valid && !aw_ready) |=> (aw.valid && $stable(aw)))
        else report_protocol_error("write address changed while stalled");
    assert property (@(posedge clk) disable iff (!rst_n)
        (w.valid && !w_ready) |=> (w.valid && $stable(w)))
        else report_protocol_error("write data changed while stalled");
    assert property (@(posedge clk) disable iff (!rst_n)
        (b.valid && !b_ready) |=> (b.valid && $stable(b)))
        else report_protocol_error("write response changed while stalled");
    // done is a single pulse right after the response handshake
    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else report_protocol_error("done stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(b.valid && b_ready))
        else report_protocol_error("done pulsed without a write response");
    // start while busy never restarts the read phase
    assert property (@(posedge clk) disable iff (!rst_n)
        (start && state != mm_pkg::IDLE && state != mm_pkg::REQ_A) |=> state != mm_pkg::REQ_A)
        else report_protocol_error("start was accepted while busy");
    assert property (@(posedge clk) !rst_n |=> (!done && !ar.valid && !aw.valid && !w.valid
        && !r_ready && !b_ready && !i_dut.mm_start && !i_dut.row_we))
        else report_protocol_error("outputs were not low after reset");

    // run limit from the number of runs
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d value errors, %0d protocol errors",
                     cycles, value_errs, proto_errs);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rst_n  = 1'b0;
        start  = 1'b0;
        a_addr = '0;
        b_addr = '0;
        c_addr = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int run = 0; run < RUNS; run++) begin
            run_matrix(run);
        end
        repeat (2) @(posedge clk);
        check_value("accepted starts", RUNS, accept_cnt);
        check_value("done pulses", RUNS, done_cnt);
        $display("%0d runs, %0d value errors, %0d protocol errors",
                 RUNS, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_axi_mem.sv
// memory model for the matrix-multiply bench
// word array with lcg fill, random ready and valid stalls
// interleaved read bursts by id, one write burst and its response
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
    input  logic             clk,
    input  logic             rst_n,
    input  mm_pkg::ar_chan_t ar_i,
    output logic             ar_ready_o,
    output mm_pkg::r_chan_t  r_o,
    input  logic             r_ready_i,
    input  mm_pkg::aw_chan_t aw_i,
    output logic             aw_ready_o,
    input  mm_pkg::w_chan_t  w_i,
    output logic             w_ready_o,
    output mm_pkg::b_chan_t  b_o,
    input  logic             b_ready_i
);

    localparam int WORDS = 256;

    logic [31:0] mem [WORDS];
    // stall stream state
    logic [31:0] lcg_q;
    // open read bursts by id, next word and beats left
    logic [7:0]  rd_word [2];
    logic [2:0]  rd_left [2];
    logic [7:0]  wr_word;
    logic        b_pend;
    logic        pick;

    // 32-bit lcg step, upper bits used for stall decisions
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // fill from seed 76, one generator step per word address
    initial begin
        logic [31:0] s;
        // channel outputs idle until the first reset edge
        ar_ready_o = 1'b0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        r_o        = '0;
        b_o        = '0;
        s = 32'd76;
        for (int k = 0; k < WORDS; k++) begin
            s = lcg_next(s);
            mem[k] = s ^ (s >> 13);
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            lcg_q      <= 32'd76;
            ar_ready_o <= 1'b0;
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            r_o        <= '0;
            b_o        <= '0;
            b_pend     <= 1'b0;
            rd_left[0] <= '0;
            rd_left[1] <= '0;
            wr_word    <= '0;
        end else begin
            lcg_q      <= lcg_next(lcg_q);
            // random back-pressure on every ready
            ar_ready_o <= lcg_q[30];
            aw_ready_o <= lcg_q[29];
            w_ready_o  <= lcg_q[28];
            if (ar_i.valid && ar_ready_o) begin
                rd_word[ar_i.id] <= ar_i.addr[9:2];
                rd_left[ar_i.id] <= ar_i.len[2:0] + 3'd1;
            end
            if (r_o.valid && r_ready_i) begin
                r_o.valid <= 1'b0;
            end
            // next beat from a random open burst
            if ((!r_o.valid || r_ready_i) && lcg_q[27]) begin
                pick = lcg_q[26];
                if (rd_left[pick] == '0) begin
                    pick = !pick;
                end
                if (rd_left[pick] != '0) begin
                    r_o.valid     <= 1'b1;
                    r_o.id        <= pick;
                    r_o.data      <= mem[rd_word[pick]];
                    r_o.last      <= (rd_left[pick] == 3'd1);
                    rd_word[pick] <= rd_word[pick] + 8'd1;
                    rd_left[pick] <= rd_left[pick] - 3'd1;
                end
            end
            if (aw_i.valid && aw_ready_o) begin
                wr_word <= aw_i.addr[9:2];
            end
            // write beats land in the word array
            if (w_i.valid && w_ready_o) begin
                mem[wr_word] <= w_i.data;
                wr_word      <= wr_word + 8'd1;
                if (w_i.last) begin
                    b_pend <= 1'b1;
                end
            end
            // response after a random delay, held until taken
            if (b_pend && !b_o.valid && lcg_q[25]) begin
                b_o.valid <= 1'b1;
                b_pend    <= 1'b0;
            end
            if (b_o.valid && b_ready_i) begin
                b_o.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mm_top.sv
// top of the matrix-multiply subsystem
// dma engine, operand feeder, 4x4 pe grid and result drain
`timescale 1ns/1ps
`default_nettype none

module mm_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [mm_pkg::ADDR_W-1:0] mat_a_addr_i,
    input  logic [mm_pkg::ADDR_W-1:0] mat_b_addr_i,
    input  logic [mm_pkg::ADDR_W-1:0] mat_c_addr_i,
    input  logic                      start_i,
    output logic                      done_o,
    output mm_pkg::ar_chan_t          ar_o,
    input  logic                      ar_ready_i,
    input  mm_pkg::r_chan_t           r_i,
    output logic                      r_ready_o,
    output mm_pkg::aw_chan_t          aw_o,
    input  logic                      aw_ready_i,
    output mm_pkg::w_chan_t           w_o,
    input  logic                      w_ready_i,
    input  mm_pkg::b_chan_t           b_i,
    output logic                      b_ready_o
);

    // operand store writes
    logic                         row_we;
    logic                         row_sel_b;
    logic [mm_pkg::IDX_W-1:0]     row_idx;
    mm_pkg::row_t                 row_data;
    // array control
    logic                         mm_start;
    logic                         mm_done;
    logic                         last_step;
    logic                         clear;
    logic [mm_pkg::RES_IDX_W-1:0] res_idx;
    mm_pkg::acc_t                 res_data;

    // a_h[j] enters grid column j, b_v[i] enters grid row i
    mm_pkg::elem_vec_t a_h [mm_pkg::SA_N+1];
    mm_pkg::elem_vec_t b_v [mm_pkg::SA_N+1];
    mm_pkg::acc_grid_t acc;

    dma_engine i_dma (
        .clk, .rst_n, .mat_a_addr_i, .mat_b_addr_i, .mat_c_addr_i, .start_i, .done_o,
        .ar_o, .ar_ready_i, .r_i, .r_ready_o, .aw_o, .aw_ready_i, .w_o, .w_ready_i,
        .b_i, .b_ready_o,
        .row_we_o(row_we), .row_sel_b_o(row_sel_b), .row_idx_o(row_idx),
        .row_data_o(row_data), .mm_start_o(mm_start), .mm_done_i(mm_done),
        .res_idx_o(res_idx), .res_data_i(res_data)
    );

    mm_feeder i_feeder (
        .clk, .rst_n,
        .row_we_i(row_we), .row_sel_b_i(row_sel_b), .row_idx_i(row_idx),
        .row_data_i(row_data), .start_i(mm_start),
        .a_o(a_h[0]), .b_o(b_v[0]), .last_step_o(last_step)
    );

    // A flows rightward, B flows downward
    for (genvar gi = 0; gi < mm_pkg::SA_N; gi++) begin : g_row
        for (genvar gj = 0; gj < mm_pkg::SA_N; gj++) begin : g_col
            mm_pe i_pe (
                .clk, .rst_n, .clear_i(clear),
                .a_i(a_h[gj][gi]), .b_i(b_v[gi][gj]),
                .a_o(a_h[gj+1][gi]), .b_o(b_v[gi+1][gj]),
                .acc_o(acc[gi][gj])
            );
        end
    end

    mm_drain i_drain (
        .clk, .rst_n, .start_i(mm_start), .last_step_i(last_step), .acc_i(acc),
        .clear_o(clear), .mm_done_o(mm_done), .res_idx_i(res_idx), .res_data_o(res_data)
    );

endmodule

`default_nettype wire

//--- logic/dma_engine.sv
// dma engine for the matrix-multiply subsystem
// reads A and B as two id-tagged bursts, starts the array, writes C back
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [mm_pkg::ADDR_W-1:0]          mat_a_addr_i,
    input  logic [mm_pkg::ADDR_W-1:0]          mat_b_addr_i,
    input  logic [mm_pkg::ADDR_W-1:0]          mat_c_addr_i,
    input  logic                               start_i,
    output logic                               done_o,
    // memory side
    output mm_pkg::ar_chan_t                   ar_o,
    input  logic                               ar_ready_i,
    input  mm_pkg::r_chan_t                    r_i,
    output logic                               r_ready_o,
    output mm_pkg::aw_chan_t                   aw_o,
    input  logic                               aw_ready_i,
    output mm_pkg::w_chan_t                    w_o,
    input  logic                               w_ready_i,
    input  mm_pkg::b_chan_t                    b_i,
    output logic                               b_ready_o,
    // operand store
    output logic                               row_we_o,
    output logic                               row_sel_b_o,
    output logic [mm_pkg::IDX_W-1:0]           row_idx_o,
    output mm_pkg::row_t                       row_data_o,
    // array control and result readback
    output logic                               mm_start_o,
    input  logic                               mm_done_i,
    output logic [mm_pkg::RES_IDX_W-1:0]       res_idx_o,
    input  mm_pkg::acc_t                       res_data_i
);

    mm_pkg::dma_state_t state_q, state_d;

    // addresses latched when a run is accepted
    logic [mm_pkg::ADDR_W-1:0] addr_a_q, addr_b_q, addr_c_q;

    // per-id beat counters and burst-finished flags
    logic [mm_pkg::IDX_W-1:0] cnt_a_q, cnt_b_q;
    logic                     done_a_q, done_b_q;
    logic                     beat_a, beat_b;
    logic                     fin_a, fin_b;

    // C element being written
    logic [mm_pkg::RES_IDX_W-1:0] wr_idx_q;

    logic accept;
    logic load_end;
    logic w_fire;

    // start only counts in IDLE
    assign accept = (state_q == mm_pkg::IDLE) && start_i;

    // read data channel, open for the whole load phase
    assign r_ready_o = (state_q == mm_pkg::LOAD);
    assign beat_a    = r_ready_o && r_i.valid && (r_i.id == mm_pkg::ID_A);
    assign beat_b    = r_ready_o && r_i.valid && (r_i.id == mm_pkg::ID_B);
    // a burst counts as finished on its last beat already
    assign fin_a     = done_a_q || (beat_a && r_i.last);
    assign fin_b     = done_b_q || (beat_b && r_i.last);
    assign load_end  = (state_q == mm_pkg::LOAD) && fin_a && fin_b;

    // each read beat is one row, routed by id
    assign row_we_o    = beat_a || beat_b;
    assign row_sel_b_o = beat_b;
    assign row_idx_o   = beat_b ? cnt_b_q : cnt_a_q;
    assign row_data_o  = r_i.data;

    // read requests, A first then B
    always_comb begin
        ar_o       = '0;
        ar_o.valid = (state_q == mm_pkg::REQ_A) || (state_q == mm_pkg::REQ_B);
        ar_o.id    = (state_q == mm_pkg::REQ_B) ? mm_pkg::ID_B : mm_pkg::ID_A;
        ar_o.addr  = (state_q == mm_pkg::REQ_B) ? addr_b_q : addr_a_q;
        ar_o.len   = mm_pkg::RD_LEN;
        ar_o.size  = mm_pkg::SIZE_4B;
        ar_o.burst = mm_pkg::BURST_INCR;
    end

    // single write burst for all of C
    always_comb begin
        aw_o       = '0;
        aw_o.valid = (state_q == mm_pkg::REQ_C);
        aw_o.addr  = addr_c_q;
        aw_o.len   = mm_pkg::WR_LEN;
        aw_o.size  = mm_pkg::SIZE_4B;
        aw_o.burst = mm_pkg::BURST_INCR;
    end

    // write data straight from the drain, row-major
    assign res_idx_o = wr_idx_q;
    always_comb begin
        w_o       = '0;
        w_o.valid = (state_q == mm_pkg::WRITE_C);
        w_o.data  = res_data_i;
        w_o.strb  = '1;
        w_o.last  = (wr_idx_q == mm_pkg::RES_IDX_W'(mm_pkg::SA_N * mm_pkg::SA_N - 1));
    end
    assign w_fire = w_o.valid && w_ready_i;

    // response is taken but not checked
    assign b_ready_o = (state_q == mm_pkg::RESP);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mm_pkg::IDLE:    if (start_i) state_d = mm_pkg::REQ_A;
            mm_pkg::REQ_A:   if (ar_ready_i) state_d = mm_pkg::REQ_B;
            mm_pkg::REQ_B:   if (ar_ready_i) state_d = mm_pkg::LOAD;
            mm_pkg::LOAD:    if (fin_a && fin_b) state_d = mm_pkg::WAIT_MM;
            mm_pkg::WAIT_MM: if (mm_done_i) state_d = mm_pkg::REQ_C;
            mm_pkg::REQ_C:   if (aw_ready_i) state_d = mm_pkg::WRITE_C;
            mm_pkg::WRITE_C: if (w_fire && w_o.last) state_d = mm_pkg::RESP;
            mm_pkg::RESP:    if (b_i.valid) state_d = mm_pkg::IDLE;
            default:         state_d = mm_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= mm_pkg::IDLE;
            cnt_a_q    <= '0;
            cnt_b_q    <= '0;
            done_a_q   <= 1'b0;
            done_b_q   <= 1'b0;
            wr_idx_q   <= '0;
            mm_start_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            state_q    <= state_d;
            // one cycle after the eighth row write
            mm_start_o <= load_end;
            // one cycle after the response handshake
            done_o     <= (state_q == mm_pkg::RESP) && b_i.valid;
            if (accept) begin
                cnt_a_q  <= '0;
                cnt_b_q  <= '0;
                done_a_q <= 1'b0;
                done_b_q <= 1'b0;
                wr_idx_q <= '0;
            end
            if (beat_a) begin
                cnt_a_q <= cnt_a_q + 1'b1;
                if (r_i.last) begin
                    done_a_q <= 1'b1;
                end
            end
            if (beat_b) begin
                cnt_b_q <= cnt_b_q + 1'b1;
                if (r_i.last) begin
                    done_b_q <= 1'b1;
                end
            end
            // advance only when the beat is taken
            if (w_fire) begin
                wr_idx_q <= wr_idx_q + 1'b1;
            end
        end
    end

    // request addresses
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_a_q <= mat_a_addr_i;
            addr_b_q <= mat_b_addr_i;
            addr_c_q <= mat_c_addr_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/mm_drain.sv
// result collector for the array
// clears the grid at start, captures C at the end, serves it by index
`timescale 1ns/1ps
`default_nettype none

module mm_drain (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic                         last_step_i,
    input  mm_pkg::acc_grid_t            acc_i,
    output logic                         clear_o,
    output logic                         mm_done_o,
    input  logic [mm_pkg::RES_IDX_W-1:0] res_idx_i,
    output mm_pkg::acc_t                 res_data_o
);

    // feeder register then pe register
    logic [1:0]   last_q;
    // row-major copy of C
    mm_pkg::acc_t cap_q [mm_pkg::SA_N * mm_pkg::SA_N];

    // zero accumulators in the same cycle as mm_start
    assign clear_o = start_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q    <= '0;
            mm_done_o <= 1'b0;
        end else begin
            last_q    <= {last_q[0], last_step_i};
            mm_done_o <= last_q[1];
        end
    end

    // accumulators hold their final sums while last_q[1] is high
    always_ff @(posedge clk) begin
        if (last_q[1]) begin
            for (int i = 0; i < mm_pkg::SA_N; i++) begin
                for (int j = 0; j < mm_pkg::SA_N; j++) begin
                    cap_q[i*mm_pkg::SA_N+j] <= acc_i[i][j];
                end
            end
        end
    end

    // stays valid while a new run clears the grid
    assign res_data_o = cap_q[res_idx_i];

endmodule

`default_nettype wire

//--- logic/mm_feeder.sv
// operand store for the rows of A and B
// feeds the array edges with diagonal skew and flags the last step
`timescale 1ns/1ps
`default_nettype none

module mm_feeder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     row_we_i,
    input  logic                     row_sel_b_i,
    input  logic [mm_pkg::IDX_W-1:0] row_idx_i,
    input  mm_pkg::row_t             row_data_i,
    input  logic                     start_i,
    // one element per grid row
    output mm_pkg::elem_vec_t        a_o,
    // one element per grid column
    output mm_pkg::elem_vec_t        b_o,
    output logic                     last_step_o
);

    // skew makes the run last 3n-2 steps
    localparam int STEP_N = 3 * mm_pkg::SA_N - 2;
    localparam int STEP_W = $clog2(STEP_N);

    mm_pkg::row_t a_rows [mm_pkg::SA_N];
    mm_pkg::row_t b_rows [mm_pkg::SA_N];

    logic              run_q;
    logic [STEP_W-1:0] step_q;
    mm_pkg::elem_vec_t a_nxt, b_nxt;

    always_ff @(posedge clk) begin
        if (row_we_i) begin
            if (row_sel_b_i) begin
                b_rows[row_idx_i] <= row_data_i;
            end else begin
                a_rows[row_idx_i] <= row_data_i;
            end
        end
    end

    assign last_step_o = run_q && (step_q == STEP_W'(STEP_N - 1));

    // row i gets A[i][t-i], column i gets B[t-i][i], zero off the band
    always_comb begin
        for (int i = 0; i < mm_pkg::SA_N; i++) begin
            a_nxt[i] = '0;
            b_nxt[i] = '0;
            if (run_q && (step_q >= i) && (step_q < i + mm_pkg::SA_N)) begin
                a_nxt[i] = a_rows[i][step_q - i];
                b_nxt[i] = b_rows[step_q - i][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            step_q <= '0;
            a_o    <= '0;
            b_o    <= '0;
        end else begin
            // zeros between runs keep the accumulators still
            a_o <= a_nxt;
            b_o <= b_nxt;
            if (start_i) begin
                run_q  <= 1'b1;
                step_q <= '0;
            end else if (last_step_o) begin
                run_q <= 1'b0;
            end else if (run_q) begin
                step_q <= step_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mm_pe.sv
// processing element of the output-stationary array
// multiply-accumulate with operand forwarding right and down
`timescale 1ns/1ps
`default_nettype none

module mm_pe (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          clear_i,
    input  mm_pkg::elem_t a_i,
    input  mm_pkg::elem_t b_i,
    output mm_pkg::elem_t a_o,
    output mm_pkg::elem_t b_o,
    output mm_pkg::acc_t  acc_o
);

    // full-width signed product
    logic signed [2*mm_pkg::ELEM_W-1:0] prod;

    assign prod = a_i * b_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_o   <= '0;
            b_o   <= '0;
            acc_o <= '0;
        end else begin
            // forward to the right and lower neighbours
            a_o <= a_i;
            b_o <= b_i;
            // clear wins over the current product
            if (clear_i) begin
                acc_o <= '0;
            end else begin
                acc_o <= acc_o + prod;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mm_pkg.sv
// constants, element types and memory channel structs
// dma state encoding for the matrix-multiply subsystem
`default_nettype none

package mm_pkg;

    // matrix geometry
    localparam int SA_N   = 4;
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 32;

    // memory bus, one row of A or B per beat
    localparam int BUS_W  = 32;
    localparam int ADDR_W = 32;
    localparam int ID_W   = 1;
    localparam int LEN_W  = 8;

    // row index within a matrix and element index within C
    localparam int IDX_W     = $clog2(SA_N);
    localparam int RES_IDX_W = $clog2(SA_N * SA_N);

    localparam logic [ID_W-1:0]  ID_A       = ID_W'(0);
    localparam logic [ID_W-1:0]  ID_B       = ID_W'(1);
    // burst length minus one
    localparam logic [LEN_W-1:0] RD_LEN     = LEN_W'(SA_N - 1);
    localparam logic [LEN_W-1:0] WR_LEN     = LEN_W'(SA_N * SA_N - 1);
    localparam logic [1:0]       BURST_INCR = 2'd1;
    localparam logic [2:0]       SIZE_4B    = 3'd2;

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    // element k sits in byte k of the bus word
    typedef logic [SA_N-1:0][ELEM_W-1:0] row_t;
    typedef elem_t [SA_N-1:0] elem_vec_t;
    // indexed [row][col]
    typedef acc_t [SA_N-1:0][SA_N-1:0] acc_grid_t;

    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } ar_chan_t;

    typedef struct packed {
        logic             valid;
        logic [ID_W-1:0]  id;
        logic [BUS_W-1:0] data;
        logic             last;
    } r_chan_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } aw_chan_t;

    typedef struct packed {
        logic               valid;
        logic [BUS_W-1:0]   data;
        logic [BUS_W/8-1:0] strb;
        logic               last;
    } w_chan_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } b_chan_t;

    typedef enum logic [2:0] {
        IDLE,
        REQ_A,
        REQ_B,
        LOAD,
        WAIT_MM,
        REQ_C,
        WRITE_C,
        RESP
    } dma_state_t;

endpackage

`default_nettype wire
